// File: hw/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   // major opcodes, instr_raw[6:0]
   typedef enum logic [6:0] {
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111,
      OPC_JAL    = 7'b1101111,
      OPC_JALR   = 7'b1100111,
      OPC_BRANCH = 7'b1100011,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_FENCE  = 7'b0001111,
      OPC_SYSTEM = 7'b1110011
   } opcode_e;

   typedef enum logic [2:0] {
      FMT_R,
      FMT_I,
      FMT_S,
      FMT_B,
      FMT_U,
      FMT_J,
      FMT_NONE
   } fmt_e;

   // one value per rv32i / rv32m instruction
   typedef enum logic [5:0] {
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
      OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
      OP_SB, OP_SH, OP_SW,
      OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
      OP_SLLI, OP_SRLI, OP_SRAI,
      OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
      OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
      OP_FENCE, OP_FENCE_I, OP_ECALL, OP_EBREAK,
      OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI,
      // m extension
      OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
      OP_DIV, OP_DIVU, OP_REM, OP_REMU,
      OP_ILLEGAL
   } op_e;

   // funct7 patterns
   localparam logic [6:0] F7_BASE   = 7'b0000000;
   localparam logic [6:0] F7_ALT    = 7'b0100000;
   localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

// File: hw/format_classify.sv
`timescale 1ns/1ns
`default_nettype none

module format_classify
   import rv_decode_pkg::*;
(
   input  wire logic [XLEN-1:0]       instr_raw,
   output fmt_e                       fmt,
   output logic [REG_ADDR_W-1:0]      dec_rd,
   output logic [REG_ADDR_W-1:0]      dec_rs1,
   output logic [REG_ADDR_W-1:0]      dec_rs2
);

   opcode_e opcode;
   logic    keep_rd;
   logic    keep_rs1;
   logic    keep_rs2;

   assign opcode = opcode_e'(instr_raw[6:0]);

   always_comb begin
      case (opcode)
         OPC_OP:                                   fmt = FMT_R;
         OPC_JALR, OPC_LOAD, OPC_OP_IMM,
         OPC_FENCE, OPC_SYSTEM:                    fmt = FMT_I;
         OPC_STORE:                                fmt = FMT_S;
         OPC_BRANCH:                               fmt = FMT_B;
         OPC_LUI, OPC_AUIPC:                       fmt = FMT_U;
         OPC_JAL:                                  fmt = FMT_J;
         default:                                  fmt = FMT_NONE;
      endcase
   end

   // fields the format does not carry read as x0
   assign keep_rd  = fmt inside {FMT_R, FMT_I, FMT_U, FMT_J};
   assign keep_rs1 = fmt inside {FMT_R, FMT_I, FMT_S, FMT_B};
   assign keep_rs2 = fmt inside {FMT_R, FMT_S, FMT_B};

   assign dec_rd  = keep_rd  ? instr_raw[11:7]  : '0;
   assign dec_rs1 = keep_rs1 ? instr_raw[19:15] : '0;
   assign dec_rs2 = keep_rs2 ? instr_raw[24:20] : '0;

endmodule

`default_nettype wire

// File: hw/imm_gen.sv
`timescale 1ns/1ns
`default_nettype none

module imm_gen
   import rv_decode_pkg::*;
(
   input  wire logic [XLEN-1:0] instr_raw,
   input  wire fmt_e            fmt,
   output logic [XLEN-1:0]      dec_imm
);

   logic sign;

   assign sign = instr_raw[31];

   always_comb begin
      case (fmt)
         FMT_I: begin
            dec_imm = {{(XLEN-12){sign}}, instr_raw[31:20]};
         end
         FMT_S: begin
            dec_imm = {{(XLEN-12){sign}}, instr_raw[31:25], instr_raw[11:7]};
         end
         FMT_B: begin
            // offset in halfwords, bit 0 always zero
            dec_imm = {{(XLEN-12){sign}}, instr_raw[7], instr_raw[30:25],
                       instr_raw[11:8], 1'b0};
         end
         FMT_U: begin
            dec_imm = {instr_raw[31:12], 12'b0};
         end
         FMT_J: begin
            dec_imm = {{(XLEN-20){sign}}, instr_raw[19:12], instr_raw[20],
                       instr_raw[30:21], 1'b0};
         end
         default: begin
            dec_imm = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: hw/op_decode.sv
`timescale 1ns/1ns
`default_nettype none

module op_decode
   import rv_decode_pkg::*;
(
   input  wire logic [XLEN-1:0] instr_raw,
   output op_e                  dec_op
);

   opcode_e    opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       rd_rs1_zero;
   logic [11:0] sys_imm;

   assign opcode      = opcode_e'(instr_raw[6:0]);
   assign funct3      = instr_raw[14:12];
   assign funct7      = instr_raw[31:25];
   assign rd_rs1_zero = (instr_raw[11:7] == 5'd0) && (instr_raw[19:15] == 5'd0);
   assign sys_imm     = instr_raw[31:20];

   always_comb begin
      dec_op = OP_ILLEGAL;
      case (opcode)
         OPC_LUI:   dec_op = OP_LUI;
         OPC_AUIPC: dec_op = OP_AUIPC;
         OPC_JAL:   dec_op = OP_JAL;
         OPC_JALR: begin
            if (funct3 == 3'b000)
               dec_op = OP_JALR;
         end
         OPC_BRANCH: begin
            case (funct3)
               3'b000:  dec_op = OP_BEQ;
               3'b001:  dec_op = OP_BNE;
               3'b100:  dec_op = OP_BLT;
               3'b101:  dec_op = OP_BGE;
               3'b110:  dec_op = OP_BLTU;
               3'b111:  dec_op = OP_BGEU;
               default: dec_op = OP_ILLEGAL;
            endcase
         end
         OPC_LOAD: begin
            case (funct3)
               3'b000:  dec_op = OP_LB;
               3'b001:  dec_op = OP_LH;
               3'b010:  dec_op = OP_LW;
               3'b100:  dec_op = OP_LBU;
               3'b101:  dec_op = OP_LHU;
               default: dec_op = OP_ILLEGAL;
            endcase
         end
         OPC_STORE: begin
            case (funct3)
               3'b000:  dec_op = OP_SB;
               3'b001:  dec_op = OP_SH;
               3'b010:  dec_op = OP_SW;
               default: dec_op = OP_ILLEGAL;
            endcase
         end
         OPC_OP_IMM: begin
            case (funct3)
               3'b000: dec_op = OP_ADDI;
               3'b010: dec_op = OP_SLTI;
               3'b011: dec_op = OP_SLTIU;
               3'b100: dec_op = OP_XORI;
               3'b110: dec_op = OP_ORI;
               3'b111: dec_op = OP_ANDI;
               // shamt in [24:20], funct7 picks logical or arithmetic
               3'b001: dec_op = (funct7 == F7_BASE) ? OP_SLLI : OP_ILLEGAL;
               default: begin
                  if (funct7 == F7_BASE)
                     dec_op = OP_SRLI;
                  else if (funct7 == F7_ALT)
                     dec_op = OP_SRAI;
               end
            endcase
         end
         OPC_OP: begin
            if (funct7 == F7_BASE) begin
               case (funct3)
                  3'b000: dec_op = OP_ADD;
                  3'b001: dec_op = OP_SLL;
                  3'b010: dec_op = OP_SLT;
                  3'b011: dec_op = OP_SLTU;
                  3'b100: dec_op = OP_XOR;
                  3'b101: dec_op = OP_SRL;
                  3'b110: dec_op = OP_OR;
                  default: dec_op = OP_AND;
               endcase
            end else if (funct7 == F7_ALT) begin
               if (funct3 == 3'b000)
                  dec_op = OP_SUB;
               else if (funct3 == 3'b101)
                  dec_op = OP_SRA;
            end else if (funct7 == F7_MULDIV) begin
               case (funct3)
                  3'b000: dec_op = OP_MUL;
                  3'b001: dec_op = OP_MULH;
                  3'b010: dec_op = OP_MULHSU;
                  3'b011: dec_op = OP_MULHU;
                  3'b100: dec_op = OP_DIV;
                  3'b101: dec_op = OP_DIVU;
                  3'b110: dec_op = OP_REM;
                  default: dec_op = OP_REMU;
               endcase
            end
         end
         OPC_FENCE: begin
            if (rd_rs1_zero && funct3 == 3'b000)
               dec_op = OP_FENCE;
            else if (rd_rs1_zero && funct3 == 3'b001)
               dec_op = OP_FENCE_I;
         end
         OPC_SYSTEM: begin
            case (funct3)
               3'b000: begin
                  if (rd_rs1_zero && sys_imm == 12'd0)
                     dec_op = OP_ECALL;
                  else if (rd_rs1_zero && sys_imm == 12'd1)
                     dec_op = OP_EBREAK;
               end
               3'b001:  dec_op = OP_CSRRW;
               3'b010:  dec_op = OP_CSRRS;
               3'b011:  dec_op = OP_CSRRC;
               3'b101:  dec_op = OP_CSRRWI;
               3'b110:  dec_op = OP_CSRRSI;
               3'b111:  dec_op = OP_CSRRCI;
               default: dec_op = OP_ILLEGAL;
            endcase
         end
         default: dec_op = OP_ILLEGAL;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/decode_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module decode_ctrl
   import rv_decode_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  rstn,
   input  wire logic                  enabled,
   input  wire logic [XLEN-1:0]       pc,
   input  wire op_e                   dec_op,
   input  wire logic [REG_ADDR_W-1:0] dec_rd,
   input  wire logic [REG_ADDR_W-1:0] dec_rs1,
   input  wire logic [REG_ADDR_W-1:0] dec_rs2,
   input  wire logic [XLEN-1:0]       dec_imm,
   output logic                       completed,
   output logic                       succeeded,
   output op_e                        op,
   output logic [REG_ADDR_W-1:0]      rd,
   output logic [REG_ADDR_W-1:0]      rs1,
   output logic [REG_ADDR_W-1:0]      rs2,
   output logic [XLEN-1:0]            imm,
   output logic [XLEN-1:0]            pc_out,
   output logic                       is_load,
   output logic                       is_store,
   output logic                       is_branch,
   output logic                       is_csr,
   output logic                       writes_to_reg
);

   logic nxt_load;
   logic nxt_store;
   logic nxt_branch;
   logic nxt_csr;
   logic nxt_wr;

   // class flags of the word being captured
   always_comb begin
      nxt_load   = dec_op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
      nxt_store  = dec_op inside {OP_SB, OP_SH, OP_SW};
      nxt_branch = dec_op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
      nxt_csr    = dec_op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC,
                                  OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};
      nxt_wr     = !(nxt_branch || nxt_store ||
                     dec_op inside {OP_FENCE, OP_FENCE_I, OP_ECALL, OP_EBREAK, OP_ILLEGAL});
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         completed     <= 1'b0;
         succeeded     <= 1'b0;
         op            <= OP_ILLEGAL;
         rd            <= '0;
         rs1           <= '0;
         rs2           <= '0;
         imm           <= '0;
         pc_out        <= '0;
         is_load       <= 1'b0;
         is_store      <= 1'b0;
         is_branch     <= 1'b0;
         is_csr        <= 1'b0;
         writes_to_reg <= 1'b0;
      end else if (enabled) begin
         // sticky until the next reset
         completed     <= 1'b1;
         succeeded     <= (dec_op != OP_ILLEGAL);
         op            <= dec_op;
         rd            <= dec_rd;
         rs1           <= dec_rs1;
         rs2           <= dec_rs2;
         imm           <= dec_imm;
         pc_out        <= pc;
         is_load       <= nxt_load;
         is_store      <= nxt_store;
         is_branch     <= nxt_branch;
         is_csr        <= nxt_csr;
         writes_to_reg <= nxt_wr;
      end
   end

endmodule

`default_nettype wire

// File: hw/rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decoder
   import rv_decode_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  rstn,
   input  wire logic                  enabled,
   input  wire logic [XLEN-1:0]       pc,
   input  wire logic [XLEN-1:0]       instr_raw,
   output logic [REG_ADDR_W-1:0]      rf_rs1,
   output logic [REG_ADDR_W-1:0]      rf_rs2,
   output logic                       completed,
   output logic                       succeeded,
   output op_e                        op,
   output logic [REG_ADDR_W-1:0]      rd,
   output logic [REG_ADDR_W-1:0]      rs1,
   output logic [REG_ADDR_W-1:0]      rs2,
   output logic [XLEN-1:0]            imm,
   output logic [XLEN-1:0]            pc_out,
   output logic                       is_load,
   output logic                       is_store,
   output logic                       is_branch,
   output logic                       is_csr,
   output logic                       writes_to_reg
);

   fmt_e                  fmt;
   op_e                   dec_op;
   logic [REG_ADDR_W-1:0] dec_rd;
   logic [REG_ADDR_W-1:0] dec_rs1;
   logic [REG_ADDR_W-1:0] dec_rs2;
   logic [XLEN-1:0]       dec_imm;

   // unmasked source fields for an early register file read
   assign rf_rs1 = instr_raw[19:15];
   assign rf_rs2 = instr_raw[24:20];

   format_classify u_fmt (
      .instr_raw (instr_raw),
      .fmt       (fmt),
      .dec_rd    (dec_rd),
      .dec_rs1   (dec_rs1),
      .dec_rs2   (dec_rs2)
   );

   imm_gen u_imm (
      .instr_raw (instr_raw),
      .fmt       (fmt),
      .dec_imm   (dec_imm)
   );

   op_decode u_op (
      .instr_raw (instr_raw),
      .dec_op    (dec_op)
   );

   decode_ctrl u_ctrl (
      .clk           (clk),
      .rstn          (rstn),
      .enabled       (enabled),
      .pc            (pc),
      .dec_op        (dec_op),
      .dec_rd        (dec_rd),
      .dec_rs1       (dec_rs1),
      .dec_rs2       (dec_rs2),
      .dec_imm       (dec_imm),
      .completed     (completed),
      .succeeded     (succeeded),
      .op            (op),
      .rd            (rd),
      .rs1           (rs1),
      .rs2           (rs2),
      .imm           (imm),
      .pc_out        (pc_out),
      .is_load       (is_load),
      .is_store      (is_store),
      .is_branch     (is_branch),
      .is_csr        (is_csr),
      .writes_to_reg (writes_to_reg)
   );

endmodule

`default_nettype wire

// File: test/tb_vectors.svh
// columns: word template, fill {rd,rs1,rs2}, keep {rd,rs1,rs2}, op, imm,
// flags {load,store,branch,csr,wr}
task automatic load_vectors;
   add_row(enc_u(20'hABCDE, OPC_LUI), 3'b100, 3'b100, OP_LUI, 32'hABCDE000, 5'b00001);
   add_row(enc_u(20'h00012, OPC_AUIPC), 3'b100, 3'b100, OP_AUIPC, 32'h00012000, 5'b00001);
   add_row(enc_j(21'h1FF800), 3'b100, 3'b100, OP_JAL, 32'hFFFFF800, 5'b00001);
   add_row(enc_j(21'h0A5554), 3'b100, 3'b100, OP_JAL, 32'h000A5554, 5'b00001);
   add_row(enc_i(12'h7FF, 3'b000, OPC_JALR), 3'b110, 3'b110, OP_JALR, 32'h000007FF, 5'b00001);
   add_row(enc_b(13'h1FFE, 3'b000), 3'b011, 3'b011, OP_BEQ, 32'hFFFFFFFE, 5'b00100);
   add_row(enc_b(13'h0FFE, 3'b001), 3'b011, 3'b011, OP_BNE, 32'h00000FFE, 5'b00100);
   add_row(enc_b(13'h1000, 3'b100), 3'b011, 3'b011, OP_BLT, 32'hFFFFF000, 5'b00100);
   add_row(enc_b(13'h0554, 3'b101), 3'b011, 3'b011, OP_BGE, 32'h00000554, 5'b00100);
   add_row(enc_b(13'h0AAA, 3'b110), 3'b011, 3'b011, OP_BLTU, 32'h00000AAA, 5'b00100);
   add_row(enc_b(13'h1556, 3'b111), 3'b011, 3'b011, OP_BGEU, 32'hFFFFF556, 5'b00100);
   add_row(enc_i(12'hFFF, 3'b000, OPC_LOAD), 3'b110, 3'b110, OP_LB, 32'hFFFFFFFF, 5'b10001);
   add_row(enc_i(12'h800, 3'b001, OPC_LOAD), 3'b110, 3'b110, OP_LH, 32'hFFFFF800, 5'b10001);
   add_row(enc_i(12'h123, 3'b010, OPC_LOAD), 3'b110, 3'b110, OP_LW, 32'h00000123, 5'b10001);
   add_row(enc_i(12'h7F0, 3'b100, OPC_LOAD), 3'b110, 3'b110, OP_LBU, 32'h000007F0, 5'b10001);
   add_row(enc_i(12'h004, 3'b101, OPC_LOAD), 3'b110, 3'b110, OP_LHU, 32'h00000004, 5'b10001);
   add_row(enc_s(12'h801, 3'b000), 3'b011, 3'b011, OP_SB, 32'hFFFFF801, 5'b01000);
   add_row(enc_s(12'h07F, 3'b001), 3'b011, 3'b011, OP_SH, 32'h0000007F, 5'b01000);
   add_row(enc_s(12'hFA5, 3'b010), 3'b011, 3'b011, OP_SW, 32'hFFFFFFA5, 5'b01000);
   add_row(enc_i(12'h800, 3'b000, OPC_OP_IMM), 3'b110, 3'b110, OP_ADDI, 32'hFFFFF800, 5'b00001);
   add_row(enc_i(12'h001, 3'b010, OPC_OP_IMM), 3'b110, 3'b110, OP_SLTI, 32'h00000001, 5'b00001);
   add_row(enc_i(12'hFFE, 3'b011, OPC_OP_IMM), 3'b110, 3'b110, OP_SLTIU, 32'hFFFFFFFE, 5'b00001);
   add_row(enc_i(12'h555, 3'b100, OPC_OP_IMM), 3'b110, 3'b110, OP_XORI, 32'h00000555, 5'b00001);
   add_row(enc_i(12'hAAA, 3'b110, OPC_OP_IMM), 3'b110, 3'b110, OP_ORI, 32'hFFFFFAAA, 5'b00001);
   add_row(enc_i(12'h0FF, 3'b111, OPC_OP_IMM), 3'b110, 3'b110, OP_ANDI, 32'h000000FF, 5'b00001);
   add_row(enc_i({F7_BASE, 5'd13}, 3'b001, OPC_OP_IMM), 3'b110, 3'b110, OP_SLLI,
           32'h0000000D, 5'b00001);
   add_row(enc_i({F7_BASE, 5'd31}, 3'b101, OPC_OP_IMM), 3'b110, 3'b110, OP_SRLI,
           32'h0000001F, 5'b00001);
   add_row(enc_i({F7_ALT, 5'd7}, 3'b101, OPC_OP_IMM), 3'b110, 3'b110, OP_SRAI,
           32'h00000407, 5'b00001);
   add_row(enc_r(F7_BASE, 3'b000), 3'b111, 3'b111, OP_ADD, 32'h0, 5'b00001);
   add_row(enc_r(F7_ALT, 3'b000), 3'b111, 3'b111, OP_SUB, 32'h0, 5'b00001);
   add_row(enc_r(F7_BASE, 3'b001), 3'b111, 3'b111, OP_SLL, 32'h0, 5'b00001);
   add_row(enc_r(F7_BASE, 3'b010), 3'b111, 3'b111, OP_SLT, 32'h0, 5'b00001);
   add_row(enc_r(F7_BASE, 3'b011), 3'b111, 3'b111, OP_SLTU, 32'h0, 5'b00001);
   add_row(enc_r(F7_BASE, 3'b100), 3'b111, 3'b111, OP_XOR, 32'h0, 5'b00001);
   add_row(enc_r(F7_BASE, 3'b101), 3'b111, 3'b111, OP_SRL, 32'h0, 5'b00001);
   add_row(enc_r(F7_ALT, 3'b101), 3'b111, 3'b111, OP_SRA, 32'h0, 5'b00001);
   add_row(enc_r(F7_BASE, 3'b110), 3'b111, 3'b111, OP_OR, 32'h0, 5'b00001);
   add_row(enc_r(F7_BASE, 3'b111), 3'b111, 3'b111, OP_AND, 32'h0, 5'b00001);
   add_row(enc_r(F7_MULDIV, 3'b000), 3'b111, 3'b111, OP_MUL, 32'h0, 5'b00001);
   add_row(enc_r(F7_MULDIV, 3'b001), 3'b111, 3'b111, OP_MULH, 32'h0, 5'b00001);
   add_row(enc_r(F7_MULDIV, 3'b010), 3'b111, 3'b111, OP_MULHSU, 32'h0, 5'b00001);
   add_row(enc_r(F7_MULDIV, 3'b011), 3'b111, 3'b111, OP_MULHU, 32'h0, 5'b00001);
   add_row(enc_r(F7_MULDIV, 3'b100), 3'b111, 3'b111, OP_DIV, 32'h0, 5'b00001);
   add_row(enc_r(F7_MULDIV, 3'b101), 3'b111, 3'b111, OP_DIVU, 32'h0, 5'b00001);
   add_row(enc_r(F7_MULDIV, 3'b110), 3'b111, 3'b111, OP_REM, 32'h0, 5'b00001);
   add_row(enc_r(F7_MULDIV, 3'b111), 3'b111, 3'b111, OP_REMU, 32'h0, 5'b00001);
   add_row(enc_i(12'h0FF, 3'b000, OPC_FENCE), 3'b000, 3'b110, OP_FENCE, 32'h000000FF, 5'b00000);
   add_row(enc_i(12'h000, 3'b001, OPC_FENCE), 3'b000, 3'b110, OP_FENCE_I, 32'h0, 5'b00000);
   add_row(enc_i(12'h000, 3'b000, OPC_SYSTEM), 3'b000, 3'b110, OP_ECALL, 32'h0, 5'b00000);
   add_row(enc_i(12'h001, 3'b000, OPC_SYSTEM), 3'b000, 3'b110, OP_EBREAK, 32'h1, 5'b00000);
   add_row(enc_i(12'h300, 3'b001, OPC_SYSTEM), 3'b110, 3'b110, OP_CSRRW, 32'h00000300, 5'b00011);
   add_row(enc_i(12'hC00, 3'b010, OPC_SYSTEM), 3'b110, 3'b110, OP_CSRRS, 32'hFFFFFC00, 5'b00011);
   add_row(enc_i(12'h341, 3'b011, OPC_SYSTEM), 3'b110, 3'b110, OP_CSRRC, 32'h00000341, 5'b00011);
   add_row(enc_i(12'h305, 3'b101, OPC_SYSTEM), 3'b110, 3'b110, OP_CSRRWI, 32'h00000305, 5'b00011);
   add_row(enc_i(12'hF14, 3'b110, OPC_SYSTEM), 3'b110, 3'b110, OP_CSRRSI, 32'hFFFFFF14, 5'b00011);
   add_row(enc_i(12'h7C0, 3'b111, OPC_SYSTEM), 3'b110, 3'b110, OP_CSRRCI, 32'h000007C0, 5'b00011);
   // illegal words
   add_row(32'h0000007F, 3'b111, 3'b000, OP_ILLEGAL, 32'h0, 5'b00000);
   add_row(enc_r(7'b0010000, 3'b000), 3'b111, 3'b111, OP_ILLEGAL, 32'h0, 5'b00000);
   add_row(enc_i(12'h000, 3'b000, OPC_FENCE) | 32'h00000180, 3'b000, 3'b110, OP_ILLEGAL,
           32'h0, 5'b00000);
endtask

// File: test/tb_rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_decoder
   import rv_decode_pkg::*;
;

   logic                  clk;
   logic                  rstn;
   logic                  enabled;
   logic [XLEN-1:0]       pc;
   logic [XLEN-1:0]       instr_raw;
   logic [REG_ADDR_W-1:0] rf_rs1;
   logic [REG_ADDR_W-1:0] rf_rs2;
   logic                  completed;
   logic                  succeeded;
   op_e                   op;
   logic [REG_ADDR_W-1:0] rd;
   logic [REG_ADDR_W-1:0] rs1;
   logic [REG_ADDR_W-1:0] rs2;
   logic [XLEN-1:0]       imm;
   logic [XLEN-1:0]       pc_out;
   logic                  is_load;
   logic                  is_store;
   logic                  is_branch;
   logic                  is_csr;
   logic                  writes_to_reg;

   logic [31:0] t_word[$];
   logic [2:0]  t_fill[$];
   logic [2:0]  t_keep[$];
   op_e         t_op[$];
   logic [31:0] t_imm[$];
   logic [4:0]  t_flags[$];
   int          errors = 0;

   rv_decoder u_dut (.*);

   // instruction encoders with the register fields left zero
   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
      return {f7, 10'd0, f3, 5'd0, 7'(OPC_OP)};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] i, input logic [2:0] f3,
                                         input logic [6:0] opc);
      return {i, 5'd0, f3, 5'd0, opc};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] i, input logic [2:0] f3);
      return {i[11:5], 10'd0, f3, i[4:0], 7'(OPC_STORE)};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] i, input logic [2:0] f3);
      return {i[12], i[10:5], 10'd0, f3, i[4:1], i[11], 7'(OPC_BRANCH)};
   endfunction

   function automatic logic [31:0] enc_u(input logic [19:0] i, input logic [6:0] opc);
      return {i, 5'd0, opc};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] i);
      return {i[20], i[10:1], i[11], i[19:12], 5'd0, 7'(OPC_JAL)};
   endfunction

   task automatic add_row(input logic [31:0] word, input logic [2:0] fill,
                          input logic [2:0] keep, input op_e exp_op,
                          input logic [31:0] exp_imm, input logic [4:0] flags);
      t_word.push_back(word);
      t_fill.push_back(fill);
      t_keep.push_back(keep);
      t_op.push_back(exp_op);
      t_imm.push_back(exp_imm);
      t_flags.push_back(flags);
   endtask

   `include "tb_vectors.svh"

   task automatic check(input string what, input logic [31:0] act, input logic [31:0] exp);
      if (act !== exp) begin
         errors++;
         $display("ERR %0t ns: %s is %h, expected %h", $time, what, act, exp);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // watchdog allows 4 cycles per row plus 20
   initial begin
      #1;
      #((t_word.size() * 4 + 20) * 100);
      $display("timeout: the run did not finish in time");
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      logic [31:0] w;
      logic [31:0] r;
      logic [4:0]  f;
      logic [31:0] last_pc;
      op_e         last_op;
      int          n;

      void'($urandom(32'hb2c4_243e));
      rstn      = 1'b1;
      enabled   = 1'b0;
      pc        = '0;
      instr_raw = '0;
      load_vectors();
      repeat (2) @(posedge clk);
      @(negedge clk);
      rstn = 1'b0;

      check("completed after reset", 32'(completed), 32'd0);
      check("succeeded after reset", 32'(succeeded), 32'd0);
      check("op after reset", 32'(op), 32'(OP_ILLEGAL));
      check("flags after reset",
            32'({is_load, is_store, is_branch, is_csr, writes_to_reg}), 32'd0);

      for (int i = 0; i < t_word.size(); i++) begin
         w = t_word[i];
         r = $urandom;
         if (t_fill[i][2])
            w[11:7] = r[4:0];
         if (t_fill[i][1])
            w[19:15] = r[9:5];
         if (t_fill[i][0])
            w[24:20] = r[14:10];
         instr_raw = w;
         pc        = $urandom & 32'hFFFF_FFFC;
         enabled   = 1'b1;
         @(posedge clk);
         @(negedge clk);
         enabled = 1'b0;
         f = t_flags[i];
         check($sformatf("row %0d op", i), 32'(op), 32'(t_op[i]));
         check($sformatf("row %0d succeeded", i), 32'(succeeded),
               32'(t_op[i] != OP_ILLEGAL));
         check($sformatf("row %0d completed", i), 32'(completed), 32'd1);
         check($sformatf("row %0d rd", i), 32'(rd), t_keep[i][2] ? 32'(w[11:7]) : 32'd0);
         check($sformatf("row %0d rs1", i), 32'(rs1), t_keep[i][1] ? 32'(w[19:15]) : 32'd0);
         check($sformatf("row %0d rs2", i), 32'(rs2), t_keep[i][0] ? 32'(w[24:20]) : 32'd0);
         check($sformatf("row %0d imm", i), imm, t_imm[i]);
         check($sformatf("row %0d pc_out", i), pc_out, pc);
         check($sformatf("row %0d flags", i),
               32'({is_load, is_store, is_branch, is_csr, writes_to_reg}), 32'(f));
      end

      // new word and pc with enabled low
      n         = t_word.size() - 1;
      last_op   = t_op[n];
      last_pc   = pc;
      instr_raw = enc_r(F7_BASE, 3'b000) | (32'd21 << 15) | (32'd10 << 20);
      pc        = ~last_pc & 32'hFFFF_FFFC;
      #10;
      check("rf_rs1 early read", 32'(rf_rs1), 32'd21);
      check("rf_rs2 early read", 32'(rf_rs2), 32'd10);
      @(posedge clk);
      @(negedge clk);
      check("op hold", 32'(op), 32'(last_op));
      check("succeeded hold", 32'(succeeded), 32'(last_op != OP_ILLEGAL));
      check("rs1 hold", 32'(rs1), t_keep[n][1] ? 32'(w[19:15]) : 32'd0);
      check("rs2 hold", 32'(rs2), t_keep[n][0] ? 32'(w[24:20]) : 32'd0);
      check("flags hold",
            32'({is_load, is_store, is_branch, is_csr, writes_to_reg}), 32'(t_flags[n]));
      check("pc_out hold", pc_out, last_pc);
      check("completed hold", 32'(completed), 32'd1);

      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
+incdir+test
hw/rv_decode_pkg.sv
hw/format_classify.sv
hw/imm_gen.sv
hw/op_decode.sv
hw/decode_ctrl.sv
hw/rv_decoder.sv
test/tb_rv_decoder.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_rv_decoder -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "Simulation PASSED"; then
   exit 0
fi
exit 1
